// ==== fpcmp.f ====
hw/fp_cmp_pkg.sv
hw/axil_pkg.sv
hw/fp_unpack.sv
hw/fp_cmp.sv
hw/fp_cmp_regs.sv
hw/fp_cmp_top.sv
tb/fp_cmp_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the fpcmp testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f fpcmp.f --top-module fp_cmp_tb -o fp_cmp_sim &&
./obj_dir/fp_cmp_sim | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb/fp_cmp_tb.sv ====
`timescale 1ns/1ps

module fp_cmp_tb import fp_cmp_pkg::*, axil_pkg::*; ();

  localparam int AXI_ADDR_W = 5;
  // about 350 compares at under 20 cycles each, with wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  localparam logic [63:0] D_ONE     = 64'h3FF0_0000_0000_0000;
  localparam logic [63:0] D_TWO     = 64'h4000_0000_0000_0000;
  localparam logic [63:0] D_NEG_ONE = 64'hBFF0_0000_0000_0000;
  localparam logic [63:0] D_NEG_TWO = 64'hC000_0000_0000_0000;
  localparam logic [63:0] D_PZERO   = 64'h0000_0000_0000_0000;
  localparam logic [63:0] D_NZERO   = 64'h8000_0000_0000_0000;
  localparam logic [63:0] D_INF     = 64'h7FF0_0000_0000_0000;
  localparam logic [63:0] D_QNAN    = 64'h7FF8_0000_0000_0000;
  localparam logic [63:0] D_SNAN    = 64'h7FF0_0000_0000_0001;
  localparam logic [63:0] S_ONE     = 64'h0000_0000_3F80_0000;
  localparam logic [63:0] S_NZERO   = 64'h0000_0000_8000_0000;
  localparam logic [63:0] S_SUB_MIN = 64'h0000_0000_0000_0001;
  localparam logic [63:0] S_SUB_BIG = 64'h0000_0000_0040_0000;
  localparam logic [63:0] S_NORM    = 64'h0000_0000_0080_0000; // smallest normal
  localparam logic [63:0] S_NEG_SUB = 64'h0000_0000_8000_0001;
  localparam logic [63:0] S_QNAN    = 64'h0000_0000_7FC0_0000;
  localparam logic [63:0] S_SNAN    = 64'h0000_0000_7F80_0001;

  logic                  clk;
  logic                  arst_n;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [31:0]           wdata;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [AXI_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [31:0]           rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;

  logic [31:0] lcg_state = 32'd31;
  logic        exp_sticky = 1'b0;  // expected NV in the flags register
  int          cycle_cnt = 0;
  string       name_q[$];
  logic [63:0] exp_q[$];
  logic [63:0] act_q[$];

  fp_cmp_top #(
    .AXI_ADDR_W(AXI_ADDR_W)
  ) dut_i (
    .clock_i  (clk),
    .arst_n_i (arst_n),
    .awaddr_i (awaddr),
    .awvalid_i(awvalid),
    .awready_o(awready),
    .wdata_i  (wdata),
    .wvalid_i (wvalid),
    .wready_o (wready),
    .bresp_o  (bresp),
    .bvalid_o (bvalid),
    .bready_i (bready),
    .araddr_i (araddr),
    .arvalid_i(arvalid),
    .arready_o(arready),
    .rdata_o  (rdata),
    .rresp_o  (rresp),
    .rvalid_o (rvalid),
    .rready_i (rready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // upper halves only, the low LCG bits repeat quickly
  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    lcg_state = lcg_next(lcg_state);
    hi = lcg_state[31:16];
    lcg_state = lcg_next(lcg_state);
    return {hi, lcg_state[31:16]};
  endfunction

  function automatic logic [63:0] rand_operand(input logic fmt);
    logic [31:0] pick;
    logic [63:0] v;
    pick = rand32();
    v = {rand32(), rand32()};
    if (fmt == FMT_D) begin
      if (pick[1:0] == 2'd0) v[62:52] = '1; // inf or nan
      if (pick[1:0] == 2'd1) v[62:52] = '0;
      if (pick[3:2] == 2'd0) v[51:0] = '0;
    end else begin
      if (pick[1:0] == 2'd0) v[30:23] = '1;
      if (pick[1:0] == 2'd1) v[30:23] = '0;
      if (pick[3:2] == 2'd0) v[22:0] = '0;
    end
    return v;
  endfunction

  // returns {invalid, result} from the IEEE 754 compare rules
  function automatic logic [1:0] ref_cmp(input logic [63:0] a, input logic [63:0] b,
                                         input logic fmt, input logic [1:0] op);
    logic        sa, sb;
    logic [62:0] ma, mb;  // exponent and fraction order like the magnitude
    logic        nan_a, nan_b;
    logic        snan_a, snan_b;
    logic        zero_a, zero_b;
    logic        res;
    logic        nv;
    if (fmt == FMT_D) begin
      sa     = a[63];
      sb     = b[63];
      ma     = a[62:0];
      mb     = b[62:0];
      nan_a  = (a[62:52] == '1) && (a[51:0] != '0);
      nan_b  = (b[62:52] == '1) && (b[51:0] != '0);
      snan_a = nan_a && !a[51];
      snan_b = nan_b && !b[51];
    end else begin
      sa     = a[31];
      sb     = b[31];
      ma     = {32'd0, a[30:0]};
      mb     = {32'd0, b[30:0]};
      nan_a  = (a[30:23] == '1) && (a[22:0] != '0);
      nan_b  = (b[30:23] == '1) && (b[22:0] != '0);
      snan_a = nan_a && !a[22];
      snan_b = nan_b && !b[22];
    end
    zero_a = (ma == '0);
    zero_b = (mb == '0);
    res    = 1'b0;
    nv     = 1'b0;
    case (op)
      OP_FEQ: begin
        nv  = snan_a | snan_b;
        res = !(nan_a || nan_b) && ((zero_a && zero_b) || (sa == sb && ma == mb));
      end
      OP_FLT, OP_FLE: begin
        nv = nan_a | nan_b;
        if (nan_a || nan_b) res = 1'b0;
        else if (zero_a && zero_b) res = (op == OP_FLE);
        else if (sa != sb) res = sa;
        else if (ma == mb) res = (op == OP_FLE);
        else res = sa ? (ma > mb) : (ma < mb);
      end
      default: ;
    endcase
    return {nv, res};
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  // entered and left on a falling edge
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    awaddr  = addr[AXI_ADDR_W-1:0];
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    #1;
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    check("wready with awready", 64'd1, 64'(wready));
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    #1;
    while (!bvalid) begin
      @(negedge clk);
      #1;
    end
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
    logic [31:0] first;
    araddr  = addr[AXI_ADDR_W-1:0];
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    first = rdata;
    repeat (hold) begin  // rready held low
      @(negedge clk);
      check("rvalid held", 64'd1, 64'(rvalid));
      check("rdata held", 64'(first), 64'(rdata));
    end
    rready = 1'b1;
    #1;
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic push_compare(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
    name_q.push_back(name);
    exp_q.push_back(expected);
    act_q.push_back(actual);
  endtask

  task automatic clear_flags();
    logic [1:0] resp;
    axil_write(REG_FLAGS, 32'd0, resp);
    exp_sticky = 1'b0;
  endtask

  task automatic run_cmp(input string name, input logic [63:0] a, input logic [63:0] b,
                         input logic fmt, input logic [1:0] op);
    logic [31:0] ctrl;
    logic [31:0] data;
    logic [31:0] exp_word;
    logic [1:0]  resp;
    logic [1:0]  ref_bits;
    ctrl = '0;
    ctrl[CTRL_OP_LSB +: 2] = op;
    ctrl[CTRL_FMT_BIT]     = fmt;
    axil_write(REG_OPA_LO, a[31:0], resp);
    axil_write(REG_OPA_HI, a[63:32], resp);
    axil_write(REG_OPB_LO, b[31:0], resp);
    axil_write(REG_OPB_HI, b[63:32], resp);
    axil_write(REG_CTRL, ctrl, resp);
    check({name, " ctrl bresp"}, 64'(RESP_OKAY), 64'(resp));
    do begin
      axil_read(REG_RESULT, 0, data, resp);
    end while (!data[RESULT_DONE_BIT]);
    ref_bits = ref_cmp(a, b, fmt, op);
    exp_sticky = exp_sticky | ref_bits[1];
    exp_word = '0;
    exp_word[RESULT_DONE_BIT] = 1'b1;
    exp_word[0] = ref_bits[0];
    push_compare($sformatf("%s op%0d result", name, op), 64'(exp_word), 64'(data));
    axil_read(REG_FLAGS, 0, data, resp);
    exp_word = '0;
    exp_word[FLAG_NV] = exp_sticky;
    push_compare($sformatf("%s op%0d flags", name, op), 64'(exp_word), 64'(data));
  endtask

  task automatic cmp_all_ops(input string name, input logic [63:0] a,
                             input logic [63:0] b, input logic fmt);
    for (int k = 0; k < 3; k++) begin
      run_cmp(name, a, b, fmt, 2'(k));
    end
  endtask

  // compares results that the stimulus queued
  initial begin
    forever begin
      @(negedge clk);
      while (act_q.size() > 0) begin
        check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
      end
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [31:0] data;
    logic [1:0]  resp;
    logic [63:0] a;
    logic [63:0] b;
    logic        fmt;
    logic [1:0]  op;
    arst_n  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    repeat (2) @(negedge clk);

    cmp_all_ops("ordered 1 2", D_ONE, D_TWO, FMT_D);
    cmp_all_ops("ordered 2 1", D_TWO, D_ONE, FMT_D);
    cmp_all_ops("ordered 1 1", D_ONE, D_ONE, FMT_D);
    cmp_all_ops("ordered -1 -2", D_NEG_ONE, D_NEG_TWO, FMT_D);
    cmp_all_ops("ordered -2 1", D_NEG_TWO, D_ONE, FMT_D);
    cmp_all_ops("ordered inf 2", D_INF, D_TWO, FMT_D);

    cmp_all_ops("zeros d", D_PZERO, D_NZERO, FMT_D);
    cmp_all_ops("zeros d swap", D_NZERO, D_PZERO, FMT_D);
    cmp_all_ops("zeros s", 64'd0, S_NZERO, FMT_S);
    cmp_all_ops("sub min big", S_SUB_MIN, S_SUB_BIG, FMT_S);
    cmp_all_ops("sub big norm", S_NORM, S_SUB_BIG, FMT_S);
    cmp_all_ops("neg sub", S_NEG_SUB, S_SUB_MIN, FMT_S);
    cmp_all_ops("one norm", S_ONE, S_NORM, FMT_S);

    for (int k = 0; k < 3; k++) begin
      clear_flags();
      run_cmp("qnan d", D_QNAN, D_ONE, FMT_D, 2'(k));
      clear_flags();
      run_cmp("snan d", D_ONE, D_SNAN, FMT_D, 2'(k));
      clear_flags();
      run_cmp("qnan s", S_QNAN, S_ONE, FMT_S, 2'(k));
      clear_flags();
      run_cmp("snan s", S_SNAN, S_ONE, FMT_S, 2'(k));
    end

    clear_flags();
    run_cmp("sticky nan", D_QNAN, D_TWO, FMT_D, OP_FLT);
    run_cmp("sticky clean", D_ONE, D_TWO, FMT_D, OP_FLT);
    run_cmp("sticky clean", D_TWO, D_TWO, FMT_D, OP_FEQ);
    clear_flags();
    axil_read(REG_FLAGS, 0, data, resp);
    check("flags cleared", 64'd0, 64'(data));

    for (int i = 0; i < 300; i++) begin
      r   = rand32();
      fmt = r[0];
      op  = 2'(r[15:8] % 8'd3);
      a   = rand_operand(fmt);
      if (r[17:16] == 2'd0) b = a;
      else if (r[19:18] == 2'd0)
        b = a ^ ((fmt == FMT_D) ? 64'h8000_0000_0000_0000 : 64'h8000_0000);
      else if (r[19:18] == 2'd1) b = a ^ 64'd1; // same exponent, near value
      else b = rand_operand(fmt);
      if (exp_sticky) clear_flags();
      run_cmp($sformatf("random %0d", i), a, b, fmt, op);
    end

    axil_read(8'h1C, 0, data, resp);
    check("unmapped read rresp", 64'(RESP_SLVERR), 64'(resp));
    axil_write(REG_OPA_LO, 32'hA5A5_5A5A, resp);
    axil_read(REG_OPA_LO, 5, data, resp);
    check("held read rdata", 64'h0000_0000_A5A5_5A5A, 64'(data));
    check("held read rresp", 64'(RESP_OKAY), 64'(resp));

    wait (act_q.size() == 0);
    @(negedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== hw/fp_cmp_top.sv ====
`timescale 1ns/1ps

module fp_cmp_top import fp_cmp_pkg::*; #(
  parameter int AXI_ADDR_W = 5
) (
  input  logic                  clock_i,
  input  logic                  arst_n_i,
  input  logic [AXI_ADDR_W-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [31:0]           wdata_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  input  logic [AXI_ADDR_W-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output logic [31:0]           rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i
);

  logic [63:0]           opa;
  logic [63:0]           opb;
  logic                  fmt;
  logic [1:0]            op;
  logic [FP_REC_W-1:0]   rec_a;
  logic [FP_REC_W-1:0]   rec_b;
  logic [FP_CLASS_W-1:0] class_a;
  logic [FP_CLASS_W-1:0] class_b;
  logic                  cmp_result;
  logic [FLAG_W-1:0]     cmp_flags;

  fp_cmp_regs #(
    .AXI_ADDR_W(AXI_ADDR_W)
  ) regs_i (
    .clock_i  (clock_i),
    .arst_n_i (arst_n_i),
    .awaddr_i (awaddr_i),
    .awvalid_i(awvalid_i),
    .awready_o(awready_o),
    .wdata_i  (wdata_i),
    .wvalid_i (wvalid_i),
    .wready_o (wready_o),
    .bresp_o  (bresp_o),
    .bvalid_o (bvalid_o),
    .bready_i (bready_i),
    .araddr_i (araddr_i),
    .arvalid_i(arvalid_i),
    .arready_o(arready_o),
    .rdata_o  (rdata_o),
    .rresp_o  (rresp_o),
    .rvalid_o (rvalid_o),
    .rready_i (rready_i),
    .opa_o    (opa),
    .opb_o    (opb),
    .fmt_o    (fmt),
    .op_o     (op),
    .result_i (cmp_result),
    .flags_i  (cmp_flags)
  );

  fp_unpack unpack_a_i (
    .data_i (opa),
    .fmt_i  (fmt),
    .rec_o  (rec_a),
    .class_o(class_a)
  );

  fp_unpack unpack_b_i (
    .data_i (opb),
    .fmt_i  (fmt),
    .rec_o  (rec_b),
    .class_o(class_b)
  );

  fp_cmp cmp_i (
    .data1_i (rec_a),
    .data2_i (rec_b),
    .class1_i(class_a),
    .class2_i(class_b),
    .op_i    (op),
    .result_o(cmp_result),
    .flags_o (cmp_flags)
  );

endmodule

// ==== hw/fp_cmp_regs.sv ====
`timescale 1ns/1ps

module fp_cmp_regs import fp_cmp_pkg::*, axil_pkg::*; #(
  parameter int AXI_ADDR_W = 5
) (
  input  logic                  clock_i,
  input  logic                  arst_n_i,
  input  logic [AXI_ADDR_W-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [31:0]           wdata_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  input  logic [AXI_ADDR_W-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output logic [31:0]           rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  output logic [63:0]           opa_o,
  output logic [63:0]           opb_o,
  output logic                  fmt_o,
  output logic [1:0]            op_o,
  input  logic                  result_i,
  input  logic [FLAG_W-1:0]     flags_i
);

  logic [REG_ADDR_W-1:0] wr_addr;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic                  wr_fire;
  logic                  rd_fire;
  logic                  wr_hit;
  logic                  rd_hit;
  logic [31:0]           rd_word;

  logic              bvalid_q;
  logic              rvalid_q;
  logic              arready_q;
  logic [1:0]        bresp_q;
  logic [1:0]        rresp_q;
  logic [31:0]       rdata_q;
  logic [63:0]       opa_q;
  logic [63:0]       opb_q;
  logic              fmt_q;
  logic [1:0]        op_q;
  logic              start_q;  // datapath settles in this cycle
  logic              done_q;
  logic              result_q;
  logic [FLAG_W-1:0] flags_q;

  assign wr_addr = REG_ADDR_W'(awaddr_i);
  assign rd_addr = REG_ADDR_W'(araddr_i);

  // address and data accepted together, one write in flight
  assign wr_fire   = awvalid_i & wvalid_i & ~bvalid_q;
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;
  assign rd_fire   = arvalid_i & arready_q;

  always_comb begin
    case (wr_addr)
      REG_OPA_LO, REG_OPA_HI, REG_OPB_LO, REG_OPB_HI,
      REG_CTRL, REG_RESULT, REG_FLAGS: wr_hit = 1'b1;
      default: wr_hit = 1'b0;
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_hit  = 1'b1;
    case (rd_addr)
      REG_OPA_LO: rd_word = opa_q[31:0];
      REG_OPA_HI: rd_word = opa_q[63:32];
      REG_OPB_LO: rd_word = opb_q[31:0];
      REG_OPB_HI: rd_word = opb_q[63:32];
      REG_CTRL: begin
        rd_word[CTRL_OP_LSB +: 2] = op_q;
        rd_word[CTRL_FMT_BIT]     = fmt_q;
      end
      REG_RESULT: begin
        rd_word[RESULT_DONE_BIT] = done_q;
        rd_word[0]               = result_q;
      end
      REG_FLAGS: rd_word[FLAG_W-1:0] = flags_q;
      default: rd_hit = 1'b0;
    endcase
  end

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      arready_q <= 1'b0;
      fmt_q     <= FMT_S;
      op_q      <= OP_FLE;
      start_q   <= 1'b0;
      done_q    <= 1'b0;
      result_q  <= 1'b0;
      flags_q   <= '0;
    end else begin
      start_q <= 1'b0;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_fire) begin
        rvalid_q  <= 1'b1;
        arready_q <= 1'b0;
      end else if (rvalid_q && rready_i) begin
        rvalid_q  <= 1'b0;
        arready_q <= 1'b1;
      end else begin
        arready_q <= ~rvalid_q;
      end
      if (wr_fire && (wr_addr == REG_CTRL)) begin
        op_q    <= wdata_i[CTRL_OP_LSB +: 2];
        fmt_q   <= wdata_i[CTRL_FMT_BIT];
        start_q <= 1'b1;
        done_q  <= 1'b0;
      end
      if (start_q) begin
        result_q <= result_i;
        done_q   <= 1'b1;
        flags_q  <= flags_q | flags_i; // sticky, beats a clear
      end else if (wr_fire && (wr_addr == REG_FLAGS)) begin
        flags_q <= '0;
      end
    end
  end

  always_ff @(posedge clock_i) begin
    if (wr_fire) begin
      bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      case (wr_addr)
        REG_OPA_LO: opa_q[31:0]  <= wdata_i;
        REG_OPA_HI: opa_q[63:32] <= wdata_i;
        REG_OPB_LO: opb_q[31:0]  <= wdata_i;
        REG_OPB_HI: opb_q[63:32] <= wdata_i;
        default: ;
      endcase
    end
    if (rd_fire) begin
      rdata_q <= rd_word;
      rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign bvalid_o  = bvalid_q;
  assign bresp_o   = bresp_q;
  assign rvalid_o  = rvalid_q;
  assign rresp_o   = rresp_q;
  assign rdata_o   = rdata_q;
  assign arready_o = arready_q;
  assign opa_o     = opa_q;
  assign opb_o     = opb_q;
  assign fmt_o     = fmt_q;
  assign op_o      = op_q;

  a_bvalid_hold: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    bvalid_q && !bready_i |=> bvalid_q)
    else $error("write response dropped before bready");

  a_rvalid_hold: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    rvalid_q && !rready_i |=> rvalid_q && $stable(rdata_q))
    else $error("read response changed before rready");

endmodule

// ==== hw/fp_cmp.sv ====
`timescale 1ns/1ps

module fp_cmp import fp_cmp_pkg::*; (
  input  logic [FP_REC_W-1:0]   data1_i,
  input  logic [FP_REC_W-1:0]   data2_i,
  input  logic [FP_CLASS_W-1:0] class1_i,
  input  logic [FP_CLASS_W-1:0] class2_i,
  input  logic [1:0]            op_i,
  output logic                  result_o,
  output logic [FLAG_W-1:0]     flags_o
);

  localparam int SIGN = FP_REC_W - 1;

  logic mag_lt;
  logic mag_le;
  logic any_snan;
  logic any_nan;
  logic both_zero;
  logic diff_sign;
  logic neg;

  // exponent and fraction compare as one unsigned number
  assign mag_lt = data1_i[SIGN-1:0] < data2_i[SIGN-1:0];
  assign mag_le = data1_i[SIGN-1:0] <= data2_i[SIGN-1:0];

  assign any_snan  = class1_i[CLS_SNAN] | class2_i[CLS_SNAN];
  assign any_nan   = any_snan | class1_i[CLS_QNAN] | class2_i[CLS_QNAN];
  assign both_zero = (class1_i[CLS_NEG_ZERO] | class1_i[CLS_POS_ZERO]) &
                     (class2_i[CLS_NEG_ZERO] | class2_i[CLS_POS_ZERO]);
  assign diff_sign = data1_i[SIGN] ^ data2_i[SIGN];
  assign neg       = data1_i[SIGN];

  always_comb begin
    result_o = 1'b0;
    flags_o  = '0;
    case (op_i)
      OP_FEQ: begin
        flags_o[FLAG_NV] = any_snan; // quiet nan is silent here
        result_o = !any_nan && (both_zero || (data1_i == data2_i));
      end
      OP_FLT: begin
        flags_o[FLAG_NV] = any_nan;
        if (any_nan || both_zero) begin
          result_o = 1'b0;
        end else if (diff_sign) begin
          result_o = neg;
        end else if (neg) begin
          result_o = !mag_le; // larger magnitude is smaller
        end else begin
          result_o = mag_lt;
        end
      end
      OP_FLE: begin
        flags_o[FLAG_NV] = any_nan;
        if (any_nan) begin
          result_o = 1'b0;
        end else if (both_zero) begin
          result_o = 1'b1;
        end else if (diff_sign) begin
          result_o = neg;
        end else if (neg) begin
          result_o = !mag_lt;
        end else begin
          result_o = mag_le;
        end
      end
      default: begin
        result_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== hw/fp_unpack.sv ====
`timescale 1ns/1ps

module fp_unpack import fp_cmp_pkg::*; (
  input  logic [63:0]           data_i,
  input  logic                  fmt_i,
  output logic [FP_REC_W-1:0]   rec_o,
  output logic [FP_CLASS_W-1:0] class_o
);

  logic                  d_sign;
  logic [DBL_EXP_W-1:0]  d_exp;
  logic [DBL_FRAC_W-1:0] d_frac;
  logic                  s_sign;
  logic [SGL_EXP_W-1:0]  s_exp;
  logic [SGL_FRAC_W-1:0] s_frac;

  logic [4:0]            s_lz;        // leading zeros of the single fraction
  logic [SGL_FRAC_W-1:0] s_norm_frac;
  logic [DBL_EXP_W-1:0]  s_rec_exp;
  logic [DBL_FRAC_W-1:0] s_rec_frac;

  logic sign;
  logic exp_zero;
  logic exp_ones;
  logic frac_zero;
  logic quiet;

  assign {d_sign, d_exp, d_frac} = data_i;
  assign {s_sign, s_exp, s_frac} = data_i[31:0];

  // highest set bit wins
  always_comb begin
    s_lz = '0;
    for (int i = 0; i < SGL_FRAC_W; i++) begin
      if (s_frac[i]) s_lz = 5'(SGL_FRAC_W - 1 - i);
    end
  end

  // shift the leading one out, it becomes the hidden bit
  assign s_norm_frac = s_frac << (s_lz + 5'd1);

  always_comb begin
    if (s_exp == '1) begin
      s_rec_exp  = '1;
      s_rec_frac = {s_frac, {(DBL_FRAC_W - SGL_FRAC_W){1'b0}}};
    end else if (s_exp != '0) begin
      s_rec_exp  = DBL_EXP_W'(s_exp) + DBL_EXP_W'(SGL_TO_DBL_BIAS);
      s_rec_frac = {s_frac, {(DBL_FRAC_W - SGL_FRAC_W){1'b0}}};
    end else if (s_frac != '0) begin
      // single subnormal is a normal double
      s_rec_exp  = DBL_EXP_W'(SGL_TO_DBL_BIAS) - DBL_EXP_W'(s_lz);
      s_rec_frac = {s_norm_frac, {(DBL_FRAC_W - SGL_FRAC_W){1'b0}}};
    end else begin
      s_rec_exp  = '0;
      s_rec_frac = '0;
    end
  end

  assign rec_o = (fmt_i == FMT_S) ? {s_sign, s_rec_exp, s_rec_frac, 1'b0}
                                  : {d_sign, d_exp, d_frac, 1'b0};

  // class follows the source format
  always_comb begin
    if (fmt_i == FMT_D) begin
      sign      = d_sign;
      exp_zero  = (d_exp == '0);
      exp_ones  = (d_exp == '1);
      frac_zero = (d_frac == '0);
      quiet     = d_frac[DBL_FRAC_W-1];
    end else begin
      sign      = s_sign;
      exp_zero  = (s_exp == '0);
      exp_ones  = (s_exp == '1);
      frac_zero = (s_frac == '0);
      quiet     = s_frac[SGL_FRAC_W-1];
    end
    class_o = '0;
    if (exp_ones) begin
      if (frac_zero) class_o[sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
      else if (quiet) class_o[CLS_QNAN] = 1'b1;
      else class_o[CLS_SNAN] = 1'b1;
    end else if (exp_zero) begin
      if (frac_zero) class_o[sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
      else class_o[sign ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
    end else begin
      class_o[sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
    end
  end

  // zero class and zero recoded magnitude come from separate paths
  always_comb begin
    a_zero_class: assert ($isunknown({fmt_i, data_i}) ||
                          ((class_o[CLS_NEG_ZERO] | class_o[CLS_POS_ZERO]) ==
                           (rec_o[FP_REC_W-2:0] == '0)))
      else $error("fp_unpack zero class disagrees with recoded value");
  end

endmodule

// ==== hw/axil_pkg.sv ====
package axil_pkg;

  localparam int REG_ADDR_W = 8;

  localparam logic [REG_ADDR_W-1:0] REG_OPA_LO = 8'h00;
  localparam logic [REG_ADDR_W-1:0] REG_OPA_HI = 8'h04;
  localparam logic [REG_ADDR_W-1:0] REG_OPB_LO = 8'h08;
  localparam logic [REG_ADDR_W-1:0] REG_OPB_HI = 8'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 8'h10;
  localparam logic [REG_ADDR_W-1:0] REG_RESULT = 8'h14;
  localparam logic [REG_ADDR_W-1:0] REG_FLAGS  = 8'h18;

  // control word layout, op is two bits wide
  localparam int CTRL_OP_LSB  = 0;
  localparam int CTRL_FMT_BIT = 4;

  localparam int RESULT_DONE_BIT = 31;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== hw/fp_cmp_pkg.sv ====
package fp_cmp_pkg;

  // recoded operand, sign / double exponent / fraction with one pad bit
  localparam int FP_REC_W   = 65;
  localparam int FP_CLASS_W = 10;

  localparam int DBL_EXP_W  = 11;
  localparam int DBL_FRAC_W = 52;
  localparam int SGL_EXP_W  = 8;
  localparam int SGL_FRAC_W = 23;

  // 1023 - 127
  localparam int SGL_TO_DBL_BIAS = 896;

  // one-hot class word bit positions
  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;
  localparam int CLS_QNAN     = 9;

  // compare select, same encoding as the rm field
  localparam logic [1:0] OP_FLE = 2'd0;
  localparam logic [1:0] OP_FLT = 2'd1;
  localparam logic [1:0] OP_FEQ = 2'd2;

  localparam int FLAG_NV = 4; // invalid operation
  localparam int FLAG_W  = 5;

  localparam logic FMT_S = 1'b0;
  localparam logic FMT_D = 1'b1;

endpackage
